/* common/dense_pkg.sv */
// dense layer package
// sample format, layer constants and the shared stream types

package dense_pkg;

  // ############################
  // format and sizes
  // ############################

  // samples per input beat
  localparam int N_IN = 10;
  // Q5.10 fixed point
  localparam int SAMPLE_W = 16;
  localparam int FRAC_BITS = 10;
  // room for ten full products plus bias
  localparam int ACC_W = 36;

  // stages from accept to stage_out
  localparam int LAYER_LATENCY = 3;
  // input blocked this long after each output transfer
  localparam int GAP_CYCLES = 2;
  localparam int GAP_W = 2;

  // ############################
  // types
  // ############################

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef sample_t [N_IN-1:0] sample_vec_t;
  // product keeps 20 fraction bits
  typedef logic signed [2*SAMPLE_W-1:0] prod_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // last pipeline stage
  typedef struct packed {
    logic    valid;
    sample_t data;
  } layer_out_t;

  // ############################
  // layer constants
  // ############################

  // listed from sample 9 down to sample 0
  localparam sample_vec_t WEIGHTS = {
    16'shFA00, 16'sh0800, 16'shFF00, 16'sh0080, 16'sh0600,
    16'shFC00, 16'sh0100, 16'sh0200, 16'shFE00, 16'sh0400
  };
  // +0.25 at 20 fraction bits
  localparam acc_t BIAS = 36'sh000040000;

  localparam sample_t SAT_MAX = 16'sh7FFF;
  localparam sample_t SAT_MIN = 16'sh8000;

endpackage

/* dense/dense_pipeline.sv */
// dense layer pipeline
// multiply by weights, sum with bias, then rescale and saturate

`timescale 1ns/10ps

module dense_pipeline (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   advance,
  input  logic                   accept,
  input  dense_pkg::sample_vec_t samples,
  output dense_pkg::layer_out_t  stage_out
);
  import dense_pkg::*;

  // stage 1 holds one product per sample
  prod_t   s1_prod [N_IN];
  logic    s1_valid;

  // stage 2 holds the accumulated sum
  acc_t    s2_acc;
  logic    s2_valid;

  // stage 3 holds the rescaled result
  sample_t s3_data;
  logic    s3_valid;

  // combinational results feeding the next stage
  acc_t    sum_c;
  acc_t    shifted_c;
  sample_t sat_c;

  // ############################
  // valid bits
  // ############################

  // whole pipe holds when advance is low
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else if (advance) begin
      s1_valid <= accept;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // ############################
  // datapath
  // ############################

  // bias first, then all ten products
  always_comb begin
    sum_c = BIAS;
    for (int i = 0; i < N_IN; i++) begin
      sum_c = sum_c + acc_t'(s1_prod[i]);
    end
  end

  // back to 10 fraction bits with floor rounding
  always_comb begin
    shifted_c = s2_acc >>> FRAC_BITS;
    if (shifted_c > acc_t'(SAT_MAX)) begin
      sat_c = SAT_MAX;
    end else if (shifted_c < acc_t'(SAT_MIN)) begin
      sat_c = SAT_MIN;
    end else begin
      // in range, low bits carry the value
      sat_c = sample_t'(shifted_c);
    end
  end

  // payload moves with the valid bits
  always_ff @(posedge clk) begin
    if (advance) begin
      for (int i = 0; i < N_IN; i++) begin
        s1_prod[i] <= $signed(samples[i]) * $signed(WEIGHTS[i]);
      end
      s2_acc  <= sum_c;
      s3_data <= sat_c;
    end
  end

  assign stage_out = '{valid: s3_valid, data: s3_data};

  // ############################
  // checks
  // ############################

  // input may only enter a moving pipe
  assert property (@(posedge clk) disable iff (rst) accept |-> advance)
    else $error("input accepted while pipeline is stalled");

endmodule

/* src/flow_control.sv */
// stream flow control
// output hold register FSM, pipeline advance and input acceptance

`timescale 1ns/10ps

module flow_control (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  data_in_valid,
  output logic                  data_in_ready,
  output logic                  data_out_valid,
  output dense_pkg::sample_t    data_out,
  input  logic                  data_out_ready,
  input  dense_pkg::layer_out_t stage_out,
  input  logic                  gap_busy,
  output logic                  accept,
  output logic                  advance,
  output logic                  out_fire
);
  import dense_pkg::*;

  typedef enum logic {
    hold_empty,
    hold_full
  } hold_state_t;

  hold_state_t state;
  // result parked while consumer stalls
  sample_t     hold_data;

  // ############################
  // hold register FSM
  // ############################

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= hold_empty;
    end else begin
      case (state)
        hold_empty: begin
          // consumer missed the pipeline result
          if (stage_out.valid && !data_out_ready) begin
            state <= hold_full;
          end
        end
        hold_full: begin
          if (data_out_ready) begin
            state <= hold_empty;
          end
        end
        default: state <= hold_empty;
      endcase
    end
  end

  // captured only on the empty to full edge
  always_ff @(posedge clk) begin
    if (state == hold_empty && stage_out.valid && !data_out_ready) begin
      hold_data <= stage_out.data;
    end
  end

  // ############################
  // stream side
  // ############################

  // advance depends only on the state register
  assign advance = (state == hold_empty);

  assign data_in_ready = advance && !gap_busy;
  assign accept = data_in_valid && data_in_ready;

  // held value has priority over the pipe
  assign data_out_valid = (state == hold_full) || stage_out.valid;
  assign data_out = (state == hold_full) ? hold_data : stage_out.data;
  assign out_fire = data_out_valid && data_out_ready;

  // held result stays offered until taken
  assert property (@(posedge clk) disable iff (rst)
    data_out_valid && !data_out_ready |=> data_out_valid && $stable(data_out))
    else $error("output changed or dropped while stalled");

endmodule

/* src/output_gap_timer.sv */
// output gap timer
// blocks new input for a fixed number of cycles after each output transfer

`timescale 1ns/10ps

module output_gap_timer (
  input  logic clk,
  input  logic rst,
  input  logic out_fire,
  output logic gap_busy
);
  import dense_pkg::*;

  // cycles left in the current gap
  logic [GAP_W-1:0] gap_count;

  // ############################
  // countdown
  // ############################

  always_ff @(posedge clk) begin
    if (rst) begin
      gap_count <= '0;
    end else if (out_fire) begin
      // a new transfer restarts the gap
      gap_count <= GAP_W'(GAP_CYCLES);
    end else if (gap_count != '0) begin
      gap_count <= gap_count - 1'b1;
    end
  end

  // busy for exactly GAP_CYCLES after the transfer edge
  assign gap_busy = (gap_count != '0);

  // input block ends after GAP_CYCLES quiet cycles
  assert property (@(posedge clk) disable iff (rst)
    out_fire ##1 (!out_fire) [*GAP_CYCLES] |=> !gap_busy)
    else $error("input still blocked after the output gap");

endmodule

/* src/dense_stream_top.sv */
// dense layer with valid/ready stream ports
// connects the pipeline, flow control and output gap timer

`timescale 1ns/10ps

module dense_stream_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   data_in_valid,
  input  dense_pkg::sample_vec_t data_in,
  output logic                   data_in_ready,
  output logic                   data_out_valid,
  output dense_pkg::sample_t     data_out,
  input  logic                   data_out_ready
);
  import dense_pkg::*;

  // pipeline control
  logic       accept;
  logic       advance;
  layer_out_t stage_out;

  // gap timer handshake
  logic       out_fire;
  logic       gap_busy;

  // ############################
  // blocks
  // ############################

  dense_pipeline u_pipe (
    .clk       (clk),
    .rst       (rst),
    .advance   (advance),
    .accept    (accept),
    .samples   (data_in),
    .stage_out (stage_out)
  );

  flow_control u_flow (
    .clk            (clk),
    .rst            (rst),
    .data_in_valid  (data_in_valid),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready),
    .stage_out      (stage_out),
    .gap_busy       (gap_busy),
    .accept         (accept),
    .advance        (advance),
    .out_fire       (out_fire)
  );

  output_gap_timer u_gap (
    .clk      (clk),
    .rst      (rst),
    .out_fire (out_fire),
    .gap_busy (gap_busy)
  );

endmodule

/* testbench/tb_dense_stream.sv */
// testbench for the dense layer stream top
// file driven beats, random producer gaps and per-result consumer stalls

`timescale 1ns/10ps

module tb_dense_stream;
  import dense_pkg::*;

  localparam int MAX_LINES = 64;
  localparam int RESET_CYCLES = 10;

  // DUT ports
  logic        clk;
  logic        rst;
  logic        data_in_valid;
  sample_vec_t data_in;
  logic        data_in_ready;
  logic        data_out_valid;
  sample_t     data_out;
  logic        data_out_ready;

  // stimulus table from the data file
  sample_vec_t stim_vec [MAX_LINES];
  sample_t     stim_exp [MAX_LINES];
  int          stim_stall [MAX_LINES];
  int          n_lines;
  int          max_stall;
  bit          loaded;

  // scoreboard with one entry per accepted beat
  sample_t     exp_q [$];
  int          acc_cyc_q [$];
  int          acc_epoch_q [$];
  int          line_q [$];
  int          acc_count;
  int          out_count;
  int          cyc;
  // bumps on every stalled output cycle
  int          stall_epoch;
  int          last_fire;
  bit          fired;
  bit          prev_stalled;
  sample_t     prev_data;

  int          value_errors;
  int          protocol_errors;
  int          seed = 32'h2434;

  dense_stream_top dut0 (
    .clk            (clk),
    .rst            (rst),
    .data_in_valid  (data_in_valid),
    .data_in        (data_in),
    .data_in_ready  (data_in_ready),
    .data_out_valid (data_out_valid),
    .data_out       (data_out),
    .data_out_ready (data_out_ready)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ############################
  // stimulus file
  // ############################

  task automatic load_stim(output bit ok);
    int      fd;
    int      n;
    string   line;
    sample_t col [N_IN];
    sample_t want;
    int      st;
    n_lines = 0;
    max_stall = 0;
    fd = $fopen("testbench/dense_stim.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd) && n_lines < MAX_LINES) begin
        line = "";
        void'($fgets(line, fd));
        // skip comment and blank lines
        if (line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %d",
                      col[0], col[1], col[2], col[3], col[4],
                      col[5], col[6], col[7], col[8], col[9], want, st);
          if (n == 12) begin
            for (int i = 0; i < N_IN; i++) begin
              stim_vec[n_lines][i] = col[i];
            end
            stim_exp[n_lines] = want;
            stim_stall[n_lines] = st;
            if (st > max_stall) begin
              max_stall = st;
            end
            n_lines++;
          end
        end
      end
      $fclose(fd);
    end
    ok = (n_lines > 0);
  endtask

  // ############################
  // drivers
  // ############################

  // producer with random idle gaps that holds valid until taken
  task automatic drive_inputs();
    int gap;
    for (int p = 0; p < n_lines; p++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(negedge clk);
        data_in_valid = 1'b0;
      end
      @(negedge clk);
      data_in_valid = 1'b1;
      data_in = stim_vec[p];
      do begin
        @(posedge clk);
      end while (!data_in_ready);
    end
    @(negedge clk);
    data_in_valid = 1'b0;
  endtask

  // consumer holds ready low for the line's stall count of valid cycles
  task automatic drive_consumer();
    int held;
    for (int c = 0; c < n_lines; c++) begin
      @(negedge clk);
      data_out_ready = (stim_stall[c] == 0);
      if (stim_stall[c] != 0) begin
        held = 0;
        while (held < stim_stall[c]) begin
          @(posedge clk);
          if (data_out_valid) begin
            held++;
          end
        end
        @(negedge clk);
        data_out_ready = 1'b1;
      end
      do begin
        @(posedge clk);
      end while (!(data_out_valid && data_out_ready));
    end
  endtask

  // ############################
  // checks
  // ############################

  task automatic check_reset_state();
    assert (data_out_valid === 1'b0) else begin
      protocol_errors++;
      $display("Error: data_out_valid got %h expected 0 after reset", data_out_valid);
    end
    assert (data_in_ready === 1'b1) else begin
      protocol_errors++;
      $display("Error: data_in_ready got %h expected 1 after reset", data_in_ready);
    end
  endtask

  // value, order and latency of one output transfer
  task automatic check_output();
    sample_t want;
    int      acc_cyc;
    int      acc_epoch;
    int      idx;
    assert (exp_q.size() != 0) else begin
      protocol_errors++;
      $display("output transfer at cycle %0d with no input beat pending", cyc);
    end
    if (exp_q.size() != 0) begin
      want = exp_q.pop_front();
      acc_cyc = acc_cyc_q.pop_front();
      acc_epoch = acc_epoch_q.pop_front();
      idx = line_q.pop_front();
      assert (data_out === want) else begin
        value_errors++;
        $display("Error: data_out line %0d got %h expected %h", idx, data_out, want);
      end
      // no stall since accept, so latency is fixed
      if (acc_epoch == stall_epoch) begin
        assert (cyc - acc_cyc == LAYER_LATENCY) else begin
          protocol_errors++;
          $display("Error: latency line %0d got %h expected %h",
                   idx, cyc - acc_cyc, LAYER_LATENCY);
        end
      end
      out_count++;
    end
  endtask

  // sampled at the rising edge after inputs settled on the falling edge
  always @(posedge clk) begin
    if (!rst) begin
      cyc++;
      if (fired && cyc - last_fire <= GAP_CYCLES) begin
        assert (data_in_ready === 1'b0) else begin
          protocol_errors++;
          $display("Error: data_in_ready got %h expected 0 at cycle %0d", data_in_ready, cyc);
        end
      end
      if (prev_stalled) begin
        assert (data_out_valid === 1'b1 && data_out === prev_data) else begin
          protocol_errors++;
          $display("Error: stalled data_out got %h valid %h expected %h valid 1",
                   data_out, data_out_valid, prev_data);
        end
      end
      if (data_in_valid && data_in_ready) begin
        exp_q.push_back(stim_exp[acc_count]);
        acc_cyc_q.push_back(cyc);
        acc_epoch_q.push_back(stall_epoch);
        line_q.push_back(acc_count + 1);
        acc_count++;
      end
      if (data_out_valid && data_out_ready) begin
        check_output();
        last_fire = cyc;
        fired = 1'b1;
      end
      prev_stalled = data_out_valid && !data_out_ready;
      prev_data = data_out;
      if (prev_stalled) begin
        stall_epoch++;
      end
    end
  end

  // ############################
  // run control
  // ############################

  initial begin
    bit ok;
    rst = 1'b1;
    data_in_valid = 1'b0;
    data_in = '0;
    data_out_ready = 1'b0;
    load_stim(ok);
    if (!ok) begin
      $display("stimulus file testbench/dense_stim.txt missing or empty");
      $display("Checks failed");
      $finish;
    end else begin
      loaded = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      check_reset_state();
      fork
        drive_inputs();
        drive_consumer();
      join_none
      wait (out_count == n_lines);
      // room for any stray extra output
      repeat (LAYER_LATENCY + GAP_CYCLES + 2) @(posedge clk);
      assert (data_out_valid === 1'b0) else begin
        protocol_errors++;
        $display("output still valid after the last result");
      end
      $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

  // watchdog sized from the stimulus length
  initial begin
    int limit;
    wait (loaded);
    limit = n_lines * (LAYER_LATENCY + GAP_CYCLES + max_stall + 4) + 50 + RESET_CYCLES;
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d of %0d results seen",
             limit, out_count, n_lines);
    $display("Checks failed");
    $finish;
  end

endmodule

/* testbench/dense_stim.txt */
# columns: sample 0 .. sample 9 (hex), expected output (hex)
# last column: cycles the consumer holds ready low on that result (decimal)
0000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0100 0
0400 0000 0000 0000 0000 0000 0000 0000 0000 0000 0500 0
0000 0400 0000 0000 0000 0000 0000 0000 0000 0000 FF00 0
0400 0400 0400 0400 0400 0400 0400 0400 0400 0400 0980 0
0000 0000 0000 0000 0000 0000 0000 0000 7FFF 0000 7FFF 2
0000 0000 0000 0000 0000 0000 0000 0000 0000 7FFF 8000 0
0000 0000 0000 0000 0000 0000 FFFF 0000 0000 0000 00FF 0
0000 0000 0000 0000 0000 0000 0001 0000 0000 0000 0100 3
0000 0000 0000 0000 0000 0200 0000 0100 0000 0000 03C0 0
0000 0000 FC00 0C00 0000 0000 0000 0000 0000 0000 0200 5
0000 0000 0000 0000 1000 0000 0000 0000 0000 0000 F100 5
8000 0000 0000 0000 0000 0000 0000 0000 0000 0000 8100 0
8000 0000 0000 0000 0000 0000 0000 0000 8000 0000 8000 1
0000 0000 0000 0000 0000 0000 0005 0000 0000 0003 00FC 0
0C00 0800 0000 0000 0000 FE00 0000 0000 0000 0000 0600 4
0000 0000 0000 0000 0000 0000 0000 0000 0F00 0000 1F00 0
0000 0000 0000 0000 0000 0000 0000 0000 1000 0000 2100 0
0000 0000 0000 0000 0000 0000 0000 0000 3FF0 0000 7FFF 2
0000 0000 0000 0000 0000 0000 0000 0000 3F00 0000 7F00 0
0000 0000 0000 0000 0000 0000 0000 0007 0000 0000 00FE 6

/* tb.f */
common/dense_pkg.sv
dense/dense_pipeline.sv
src/flow_control.sv
src/output_gap_timer.sv
src/dense_stream_top.sv
testbench/tb_dense_stream.sv
